// File: hw/core_cfg_pkg.sv
/*
 * Datapath and register file dimensions shared by the core.
 * Modules pull these in with a wildcard import in their header.
 */

`default_nettype none

package core_cfg_pkg;

   // Data word width
   localparam int unsigned operand_width = 32;

   // Register number width
   localparam int unsigned rf_addr_width = 5;

   // Number of general purpose registers
   localparam int unsigned rf_words = 32;

endpackage

`default_nettype wire

// File: hw/isa_pkg.sv
/*
 * Instruction set encodings for the toy 32-bit ISA.
 * Holds opcodes, R-type function codes, both word formats and the
 * operation code handed from decode to execute.
 */

`default_nettype none

package isa_pkg;

   // Major opcodes in bits 31:26
   localparam logic [5:0] op_alu   = 6'h38;
   localparam logic [5:0] op_addi  = 6'h27;
   localparam logic [5:0] op_ori   = 6'h2a;
   localparam logic [5:0] op_movhi = 6'h06;

   // R-type function codes in bits 10:0
   localparam logic [10:0] fn_add = 11'h000;
   localparam logic [10:0] fn_sub = 11'h002;
   localparam logic [10:0] fn_and = 11'h003;
   localparam logic [10:0] fn_or  = 11'h004;
   localparam logic [10:0] fn_xor = 11'h005;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] funct;
   } instr_r_t;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } instr_i_t;

   // Opcode tells which view holds
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_movhi,
      alu_none
   } alu_op_t;

endpackage

`default_nettype wire

// File: hw/rf_ram.sv
/*
 * Register storage with one write port and one registered read port.
 * A read in the same cycle as a write to that word returns the old data.
 * While reset is high the contents are cleared one word per cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module rf_ram import core_cfg_pkg::*; (
   input  wire                        clk,
   input  wire                        rst,
   input  wire [rf_addr_width-1:0]    rdad_i,
   input  wire                        rden_i,
   output logic [operand_width-1:0]   rdda_o,
   input  wire [rf_addr_width-1:0]    wrad_i,
   input  wire                        wren_i,
   input  wire [operand_width-1:0]    wrda_i
);

   logic [operand_width-1:0] mem [rf_words];
   logic [rf_addr_width-1:0] clr_cnt;

   // Sweep pointer, parked at zero outside reset
   always_ff @(posedge clk) begin
      if (rst)
         clr_cnt <= clr_cnt + 1'b1;
      else
         clr_cnt <= '0;
   end

   always_ff @(posedge clk) begin
      if (rst)
         mem[clr_cnt] <= '0;
      else if (wren_i)
         mem[wrad_i] <= wrda_i;
   end

   // Registered read, old data on collision
   always_ff @(posedge clk) begin
      if (rden_i)
         rdda_o <= mem[rdad_i];
   end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
/*
 * Two-read-port register file built from a pair of single-read RAMs.
 * The last written value is kept aside and bypassed onto a read port
 * when its registered address matches, so back-to-back dependents work.
 */

`timescale 1ns/100ps
`default_nettype none

module reg_file import core_cfg_pkg::*; (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        padv_decode_i,
   input  wire [rf_addr_width-1:0]    rfa_adr_i,
   input  wire [rf_addr_width-1:0]    rfb_adr_i,
   input  wire [rf_addr_width-1:0]    rfd_adr_i,
   input  wire                        rf_wb_i,
   input  wire                        execute_rf_we_i,
   input  wire [operand_width-1:0]    result_i,
   output logic [operand_width-1:0]   rfa_o,
   output logic [operand_width-1:0]   rfb_o
);

   logic [operand_width-1:0] rfa_ram;
   logic [operand_width-1:0] rfb_ram;
   logic [operand_width-1:0] result_last;
   logic [rf_addr_width-1:0] rfd_last;
   logic [rf_addr_width-1:0] rfa_r;
   logic [rf_addr_width-1:0] rfb_r;
   logic                     rf_wren;

   // Writeback only when decode asked for it
   assign rf_wren = execute_rf_we_i & rf_wb_i;

   // Addresses that the RAM outputs currently belong to
   always_ff @(posedge clk) begin
      if (rst) begin
         rfa_r <= '0;
         rfb_r <= '0;
      end else if (padv_decode_i) begin
         rfa_r <= rfa_adr_i;
         rfb_r <= rfb_adr_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rfd_last    <= '0;
         result_last <= '0;
      end else if (rf_wren) begin
         rfd_last    <= rfd_adr_i;
         result_last <= result_i;
      end
   end

   // RAM misses a write made on the read edge, the bypass covers it
   assign rfa_o = (rfd_last == rfa_r) ? result_last : rfa_ram;
   assign rfb_o = (rfd_last == rfb_r) ? result_last : rfb_ram;

   rf_ram i_rfa_ram (
      .clk    (clk),
      .rst    (rst),
      .rdad_i (rfa_adr_i),
      .rden_i (padv_decode_i),
      .rdda_o (rfa_ram),
      .wrad_i (rfd_adr_i),
      .wren_i (rf_wren),
      .wrda_i (result_i)
   );

   rf_ram i_rfb_ram (
      .clk    (clk),
      .rst    (rst),
      .rdad_i (rfb_adr_i),
      .rden_i (padv_decode_i),
      .rdda_o (rfb_ram),
      .wrad_i (rfd_adr_i),
      .wren_i (rf_wren),
      .wrda_i (result_i)
   );

endmodule

`default_nettype wire

// File: hw/instr_decode.sv
/*
 * Decode stage. Accepts instruction words over valid/ready, starts the
 * register file reads from the raw word and holds the decoded fields
 * until the execute stage takes them.
 */

`timescale 1ns/100ps
`default_nettype none

module instr_decode import core_cfg_pkg::*, isa_pkg::*; (
   input  wire                        clk,
   input  wire                        rst,
   input  wire [31:0]                 instr_i,
   input  wire                        instr_valid_i,
   output logic                       instr_ready_o,
   input  wire                        padv_execute_i,
   output logic                       padv_decode_o,
   output logic [rf_addr_width-1:0]   rfa_adr_o,
   output logic [rf_addr_width-1:0]   rfb_adr_o,
   output logic [rf_addr_width-1:0]   rfd_adr_o,
   output logic                       rf_wb_o,
   output alu_op_t                    alu_op_o,
   output logic                       use_imm_o,
   output logic [operand_width-1:0]   imm_o,
   output logic                       illegal_o,
   output logic                       dec_valid_o
);

   instr_u                   word;
   alu_op_t                  alu_op_d;
   logic                     use_imm_d;
   logic [operand_width-1:0] imm_d;
   logic                     illegal_d;

   assign word = instr_i;

   // Free now, or emptied by execute on this edge
   assign instr_ready_o = !dec_valid_o | padv_execute_i;
   assign padv_decode_o = instr_valid_i & instr_ready_o;

   // ra sits in the same bits for both formats
   assign rfa_adr_o = word.r.ra;
   assign rfb_adr_o = word.r.rb;

   always_comb begin
      alu_op_d  = alu_none;
      use_imm_d = 1'b0;
      imm_d     = {{(operand_width-16){1'b0}}, word.i.imm};
      illegal_d = 1'b0;
      case (word.r.opcode)
         op_alu: begin
            case (word.r.funct)
               fn_add:  alu_op_d = alu_add;
               fn_sub:  alu_op_d = alu_sub;
               fn_and:  alu_op_d = alu_and;
               fn_or:   alu_op_d = alu_or;
               fn_xor:  alu_op_d = alu_xor;
               default: illegal_d = 1'b1;
            endcase
         end
         op_addi: begin
            alu_op_d  = alu_add;
            use_imm_d = 1'b1;
            // Sign extended, unlike the logical immediates
            imm_d     = {{(operand_width-16){word.i.imm[15]}}, word.i.imm};
         end
         op_ori: begin
            alu_op_d  = alu_or;
            use_imm_d = 1'b1;
         end
         op_movhi: begin
            alu_op_d  = alu_movhi;
            use_imm_d = 1'b1;
         end
         default: illegal_d = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid_o <= 1'b0;
         rf_wb_o     <= 1'b0;
      end else if (padv_decode_o) begin
         dec_valid_o <= 1'b1;
         // r0 stays zero, illegal words leave the registers alone
         rf_wb_o     <= !illegal_d && (word.r.rd != '0);
      end else if (padv_execute_i) begin
         dec_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_decode_o) begin
         rfd_adr_o <= word.r.rd;
         alu_op_o  <= alu_op_d;
         use_imm_o <= use_imm_d;
         imm_o     <= imm_d;
         illegal_o <= illegal_d;
      end
   end

endmodule

`default_nettype wire

// File: hw/alu_execute.sv
/*
 * Execute stage. Computes the result from the decoded fields, hands it
 * to the register file for writeback and registers it into the output
 * port, which holds steady while the consumer is not ready.
 */

`timescale 1ns/100ps
`default_nettype none

module alu_execute import core_cfg_pkg::*, isa_pkg::*; (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        dec_valid_i,
   input  alu_op_t                    alu_op_i,
   input  wire                        use_imm_i,
   input  wire [operand_width-1:0]    imm_i,
   input  wire [operand_width-1:0]    rfa_i,
   input  wire [operand_width-1:0]    rfb_i,
   input  wire [rf_addr_width-1:0]    rfd_adr_i,
   input  wire                        illegal_i,
   output logic                       padv_execute_o,
   output logic [operand_width-1:0]   alu_result_o,
   output logic [operand_width-1:0]   result_o,
   output logic [rf_addr_width-1:0]   result_rd_o,
   output logic                       result_illegal_o,
   output logic                       result_valid_o,
   input  wire                        result_ready_i
);

   logic [operand_width-1:0] opb;

   // Output slot empty or being drained, and something to move in
   assign padv_execute_o = dec_valid_i & (!result_valid_o | result_ready_i);

   assign opb = use_imm_i ? imm_i : rfb_i;

   always_comb begin
      case (alu_op_i)
         alu_add:   alu_result_o = rfa_i + opb;
         alu_sub:   alu_result_o = rfa_i - opb;
         alu_and:   alu_result_o = rfa_i & opb;
         alu_or:    alu_result_o = rfa_i | opb;
         alu_xor:   alu_result_o = rfa_i ^ opb;
         // Immediate into the upper half
         alu_movhi: alu_result_o = {opb[15:0], 16'h0000};
         default:   alu_result_o = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         result_valid_o <= 1'b0;
      else if (padv_execute_o)
         result_valid_o <= 1'b1;
      else if (result_ready_i)
         result_valid_o <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (padv_execute_o) begin
         result_o         <= alu_result_o;
         result_rd_o      <= rfd_adr_i;
         result_illegal_o <= illegal_i;
      end
   end

endmodule

`default_nettype wire

// File: hw/mini_core.sv
/*
 * Top of the three-stage datapath. Instruction words enter on a
 * valid/ready port and results leave on another, one per instruction.
 */

`timescale 1ns/100ps
`default_nettype none

module mini_core import core_cfg_pkg::*, isa_pkg::*; (
   input  wire                        clk,
   input  wire                        rst,
   input  wire [31:0]                 instr_i,
   input  wire                        instr_valid_i,
   output logic                       instr_ready_o,
   output logic [operand_width-1:0]   result_o,
   output logic [rf_addr_width-1:0]   result_rd_o,
   output logic                       result_illegal_o,
   output logic                       result_valid_o,
   input  wire                        result_ready_i
);

   logic                     padv_decode;
   logic                     padv_execute;
   logic [rf_addr_width-1:0] rfa_adr;
   logic [rf_addr_width-1:0] rfb_adr;
   logic [rf_addr_width-1:0] rfd_adr;
   logic                     rf_wb;
   alu_op_t                  alu_op;
   logic                     use_imm;
   logic [operand_width-1:0] imm;
   logic                     illegal;
   logic                     dec_valid;
   logic [operand_width-1:0] rfa;
   logic [operand_width-1:0] rfb;
   logic [operand_width-1:0] alu_result;

   instr_decode i_instr_decode (
      .clk            (clk),
      .rst            (rst),
      .instr_i        (instr_i),
      .instr_valid_i  (instr_valid_i),
      .instr_ready_o  (instr_ready_o),
      .padv_execute_i (padv_execute),
      .padv_decode_o  (padv_decode),
      .rfa_adr_o      (rfa_adr),
      .rfb_adr_o      (rfb_adr),
      .rfd_adr_o      (rfd_adr),
      .rf_wb_o        (rf_wb),
      .alu_op_o       (alu_op),
      .use_imm_o      (use_imm),
      .imm_o          (imm),
      .illegal_o      (illegal),
      .dec_valid_o    (dec_valid)
   );

   reg_file i_reg_file (
      .clk             (clk),
      .rst             (rst),
      .padv_decode_i   (padv_decode),
      .rfa_adr_i       (rfa_adr),
      .rfb_adr_i       (rfb_adr),
      .rfd_adr_i       (rfd_adr),
      .rf_wb_i         (rf_wb),
      .execute_rf_we_i (padv_execute),
      .result_i        (alu_result),
      .rfa_o           (rfa),
      .rfb_o           (rfb)
   );

   alu_execute i_alu_execute (
      .clk              (clk),
      .rst              (rst),
      .dec_valid_i      (dec_valid),
      .alu_op_i         (alu_op),
      .use_imm_i        (use_imm),
      .imm_i            (imm),
      .rfa_i            (rfa),
      .rfb_i            (rfb),
      .rfd_adr_i        (rfd_adr),
      .illegal_i        (illegal),
      .padv_execute_o   (padv_execute),
      .alu_result_o     (alu_result),
      .result_o         (result_o),
      .result_rd_o      (result_rd_o),
      .result_illegal_o (result_illegal_o),
      .result_valid_o   (result_valid_o),
      .result_ready_i   (result_ready_i)
   );

endmodule

`default_nettype wire

// File: sim/tb_mini_core.sv
/*
 * Self-checking testbench for the three-stage datapath. A reference model
 * predicts each result when its word is accepted, and concurrent assertions
 * compare what the DUT hands out and watch the output handshake.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_mini_core import core_cfg_pkg::*, isa_pkg::*; ();

   localparam int reset_cycles = 8;
   localparam int n_burst = 64;
   localparam int n_random = 300;
   // Two readback sweeps, directed words, burst and long stream
   localparam int n_instr = 2 * rf_words + 23 + n_burst + n_random;
   localparam int stim_cycles = reset_cycles + 2 * n_instr + 20;
   localparam int timeout_cycles = 2 * stim_cycles;

   logic        clk;
   logic        rst;
   logic [31:0] instr_i;
   logic        instr_valid_i;
   logic        instr_ready_o;
   logic [31:0] result_o;
   logic [4:0]  result_rd_o;
   logic        result_illegal_o;
   logic        result_valid_o;
   logic        result_ready_i;

   logic [31:0] lfsr;
   logic        gap_mode;
   int          errors = 0;
   int          checks = 0;
   int          sent = 0;
   int          cycles = 0;
   int          rst_count = 0;
   logic [31:0] model_rf [rf_words];
   // Entries are {illegal, rd, value}
   logic [37:0] exp_q [$];
   logic [31:0] head_val;
   logic [4:0]  head_rd;
   logic        head_ill;
   logic        head_ok;
   logic        accept;
   logic        consume;
   logic [31:0] word;

   assign accept  = instr_valid_i & instr_ready_o;
   assign consume = result_valid_o & result_ready_i;

   mini_core i_mini_core (
      .clk              (clk),
      .rst              (rst),
      .instr_i          (instr_i),
      .instr_valid_i    (instr_valid_i),
      .instr_ready_o    (instr_ready_o),
      .result_o         (result_o),
      .result_rd_o      (result_rd_o),
      .result_illegal_o (result_illegal_o),
      .result_valid_o   (result_valid_o),
      .result_ready_i   (result_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [31:0] r_word(input logic [10:0] fn, input logic [4:0] rd,
                                          input logic [4:0] ra, input logic [4:0] rb);
      return {op_alu, rd, ra, rb, fn};
   endfunction

   function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] ra, input logic [15:0] imm);
      return {op, rd, ra, imm};
   endfunction

   // Reference result from the ISA rules, top bit is the illegal flag
   function automatic logic [32:0] predict(input logic [31:0] w);
      logic [31:0] a;
      logic [31:0] b;
      logic [15:0] imm;
      a   = model_rf[w[20:16]];
      b   = model_rf[w[15:11]];
      imm = w[15:0];
      if (w[31:26] == op_alu) begin
         case (w[10:0])
            fn_add:  return {1'b0, a + b};
            fn_sub:  return {1'b0, a - b};
            fn_and:  return {1'b0, a & b};
            fn_or:   return {1'b0, a | b};
            fn_xor:  return {1'b0, a ^ b};
            default: return {1'b1, 32'h0};
         endcase
      end
      case (w[31:26])
         op_addi:  return {1'b0, a + {{16{imm[15]}}, imm}};
         op_ori:   return {1'b0, a | {16'h0000, imm}};
         op_movhi: return {1'b0, imm, 16'h0000};
         default:  return {1'b1, 32'h0};
      endcase
   endfunction

   always @(posedge clk) begin : model_update
      logic [32:0] pred;
      if (rst) begin
         for (int r = 0; r < rf_words; r++)
            model_rf[r] = '0;
         exp_q.delete();
      end else begin
         if (consume && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            checks++;
         end
         if (accept) begin
            pred = predict(instr_i);
            exp_q.push_back({pred[32], instr_i[25:21], pred[31:0]});
            // r0 and illegal words leave the model alone
            if (!pred[32] && instr_i[25:21] != 5'd0)
               model_rf[instr_i[25:21]] = pred[31:0];
         end
      end
      head_ok <= exp_q.size() != 0;
      if (exp_q.size() != 0)
         {head_ill, head_rd, head_val} <= exp_q[0];
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (rst)
         rst_count <= rst_count + 1;
      if (cycles >= timeout_cycles) begin
         $display("Timeout after %0d cycles, %0d results still outstanding",
                  cycles, exp_q.size());
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      consume |-> head_ok && result_o == head_val && result_rd_o == head_rd
                  && result_illegal_o == head_ill)
   else begin
      errors = errors + 1;
      $display("Error at %0t: got %h rd %0d ill %b, expected %h rd %0d ill %b (ok %b)",
               $time, $sampled(result_o), $sampled(result_rd_o),
               $sampled(result_illegal_o), $sampled(head_val), $sampled(head_rd),
               $sampled(head_ill), $sampled(head_ok));
   end

   // Held output must not move until consumed
   assert property (@(posedge clk) disable iff (rst)
      result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o)
         && $stable(result_rd_o) && $stable(result_illegal_o))
   else begin
      errors = errors + 1;
      $display("Error at %0t: result changed or dropped while stalled", $time);
   end

   assert property (@(posedge clk) disable iff (rst)
      $past(accept, 2) && $past(result_ready_i) |-> result_valid_o)
   else begin
      errors = errors + 1;
      $display("Error at %0t: result not valid one cycle after acceptance", $time);
   end

   assert property (@(posedge clk) rst && rst_count != 0 |-> !result_valid_o)
   else begin
      errors = errors + 1;
      $display("Error at %0t: result valid during reset", $time);
   end

   assert property (@(posedge clk) $fell(rst) |-> instr_ready_o)
   else begin
      errors = errors + 1;
      $display("Error at %0t: instruction port not ready after reset", $time);
   end

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Falling edge, with a fresh ready value when gaps are on
   task automatic next_cycle();
      logic [31:0] r;
      @(negedge clk);
      if (gap_mode) begin
         take_bits(2, r);
         result_ready_i = (r[1:0] != 2'b00);
      end else begin
         result_ready_i = 1'b1;
      end
   endtask

   task automatic send(input logic [31:0] w);
      logic taken;
      next_cycle();
      instr_i       = w;
      instr_valid_i = 1'b1;
      #1 taken = instr_ready_o;
      @(posedge clk);
      while (!taken) begin
         next_cycle();
         #1 taken = instr_ready_o;
         @(posedge clk);
      end
      sent++;
   endtask

   task automatic random_instr(input logic narrow, output logic [31:0] w);
      logic [31:0] sel;
      logic [31:0] rd;
      logic [31:0] ra;
      logic [31:0] rb;
      logic [31:0] imm;
      take_bits(4, sel);
      take_bits(5, rd);
      take_bits(5, ra);
      take_bits(5, rb);
      take_bits(16, imm);
      // Few registers means dense dependences
      if (narrow) begin
         rd[4:2] = '0;
         ra[4:2] = '0;
         rb[4:2] = '0;
      end
      case (sel[3:0])
         4'd0, 4'd1:        w = r_word(fn_add, rd[4:0], ra[4:0], rb[4:0]);
         4'd2, 4'd13:       w = r_word(fn_sub, rd[4:0], ra[4:0], rb[4:0]);
         4'd3:              w = r_word(fn_and, rd[4:0], ra[4:0], rb[4:0]);
         4'd4:              w = r_word(fn_or, rd[4:0], ra[4:0], rb[4:0]);
         4'd5:              w = r_word(fn_xor, rd[4:0], ra[4:0], rb[4:0]);
         4'd6, 4'd7, 4'd8:  w = i_word(op_addi, rd[4:0], ra[4:0], imm[15:0]);
         4'd9, 4'd10:       w = i_word(op_ori, rd[4:0], ra[4:0], imm[15:0]);
         4'd11, 4'd12:      w = i_word(op_movhi, rd[4:0], ra[4:0], imm[15:0]);
         4'd14:             w = r_word(11'h7ff, rd[4:0], ra[4:0], rb[4:0]);
         default:           w = i_word(6'h3f, rd[4:0], ra[4:0], imm[15:0]);
      endcase
   endtask

   // Add each register to r0 with no writeback
   task automatic readback();
      for (int r = 0; r < rf_words; r++)
         send(r_word(fn_add, 5'd0, r[4:0], 5'd0));
   endtask

   task automatic drain();
      next_cycle();
      instr_valid_i = 1'b0;
      while (exp_q.size() != 0)
         next_cycle();
      repeat (4) next_cycle();
   endtask

   initial begin
      rst            = 1'b1;
      instr_i        = '0;
      instr_valid_i  = 1'b0;
      result_ready_i = 1'b1;
      gap_mode       = 1'b0;
      lfsr           = 32'd98486;
      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;

      readback();
      // Constants and every operation, ready held high
      send(i_word(op_movhi, 5'd1, 5'd0, 16'h8765));
      send(i_word(op_ori, 5'd1, 5'd1, 16'h4321));
      send(i_word(op_ori, 5'd2, 5'd0, 16'hf0f0));
      send(i_word(op_addi, 5'd3, 5'd0, 16'hfffb));
      send(i_word(op_addi, 5'd4, 5'd3, 16'h7fff));
      send(r_word(fn_add, 5'd5, 5'd1, 5'd2));
      send(r_word(fn_sub, 5'd6, 5'd2, 5'd1));
      send(r_word(fn_and, 5'd7, 5'd1, 5'd2));
      send(r_word(fn_or, 5'd8, 5'd1, 5'd3));
      send(r_word(fn_xor, 5'd9, 5'd1, 5'd3));
      // Back-to-back chain through the bypass
      repeat (6) send(i_word(op_addi, 5'd10, 5'd10, 16'h0003));
      send(r_word(fn_add, 5'd11, 5'd10, 5'd10));
      send(r_word(fn_xor, 5'd11, 5'd11, 5'd1));
      // r0 writes are dropped, illegal words change nothing
      send(i_word(op_addi, 5'd0, 5'd1, 16'h0001));
      send(r_word(fn_add, 5'd12, 5'd0, 5'd0));
      send(i_word(6'h3f, 5'd1, 5'd1, 16'h1234));
      send(r_word(11'h7ff, 5'd2, 5'd1, 5'd2));
      send(r_word(fn_or, 5'd13, 5'd1, 5'd2));

      gap_mode = 1'b1;
      repeat (n_burst) begin
         random_instr(1'b1, word);
         send(word);
      end
      repeat (n_random) begin
         random_instr(1'b0, word);
         send(word);
      end
      readback();
      drain();

      if (checks != sent) begin
         errors = errors + 1;
         $display("%0d words were accepted but %0d results came out", sent, checks);
      end
      $display("Results checked: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
hw/core_cfg_pkg.sv
hw/isa_pkg.sv
hw/rf_ram.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/mini_core.sv
sim/tb_mini_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_mini_core \
   --Mdir "$build_dir" -o tb_mini_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/tb_mini_core" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
   echo "Simulation reported failures"
   exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$log"; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0
